// ==== mul_pkg.sv ====
package mul_pkg;

    // ********************
    // Widths
    // ********************
    localparam int XLEN     = 64;
    localparam int PROD_W   = 2 * XLEN;
    localparam int BASE_W   = 8;
    localparam int OPCODE_W = 5;

    // ********************
    // Opcodes
    // ********************
    // Low half of the product
    localparam logic [OPCODE_W-1:0] OP_MUL   = 5'b01100;
    // High half of the unsigned product
    localparam logic [OPCODE_W-1:0] OP_MULHU = 5'b01111;

    // Which part of the product goes out
    typedef enum logic [1:0] {
        SEL_LO,
        SEL_HI,
        SEL_ZERO
    } res_sel_t;

    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } prod_halves_t;

    // Full product word, or its two halves
    typedef union packed {
        logic [PROD_W-1:0] whole;
        prod_halves_t      half;
    } product_u;

endpackage

// ==== mul_if.sv ====
`timescale 1ns/100ps

// ********************
// Decode to execute
// ********************
interface op_if #(
    parameter int XLEN = mul_pkg::XLEN
) ();

    logic               valid;
    logic               ready;
    logic [XLEN-1:0]    a;
    logic [XLEN-1:0]    b;
    mul_pkg::res_sel_t  sel;

    modport src (
        output valid,
        output a,
        output b,
        output sel,
        input  ready
    );

    modport dst (
        input  valid,
        input  a,
        input  b,
        input  sel,
        output ready
    );

endinterface

// ********************
// Execute to result
// ********************
interface prod_if ();

    logic               valid;
    logic               ready;
    mul_pkg::product_u  prod;
    mul_pkg::res_sel_t  sel;

    modport src (
        output valid,
        output prod,
        output sel,
        input  ready
    );

    modport dst (
        input  valid,
        input  prod,
        input  sel,
        output ready
    );

endinterface

// ==== dadda_8x8.sv ====
`timescale 1ns/100ps

module dadda_8x8 (
    input  logic [7:0]   a,
    input  logic [7:0]   b,
    output logic [15:0]  y
);

    // Row i is a gated by b[i], so pp[i][j] sits in column i+j
    logic [7:0]   pp [8];
    logic [5:0]   s1, c1;
    logic [13:0]  s2, c2;
    logic [9:0]   s3, c3;
    logic [11:0]  s4, c4;
    logic [14:2]  fin_x, fin_y;
    logic [14:1]  cy;

    // {carry, sum} of a full adder
    function automatic logic [1:0] fa(input logic p, input logic q, input logic r);
        fa = {(p & q) | (p & r) | (q & r), p ^ q ^ r};
    endfunction

    // {carry, sum} of a half adder
    function automatic logic [1:0] ha(input logic p, input logic q);
        ha = {p & q, p ^ q};
    endfunction

    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign pp[i] = a & {8{b[i]}};
    end

    // ********************
    // Height 8 to 6
    // ********************
    assign {c1[0], s1[0]} = ha(pp[6][0], pp[5][1]);
    assign {c1[1], s1[1]} = fa(pp[7][0], pp[6][1], pp[5][2]);
    assign {c1[2], s1[2]} = ha(pp[4][3], pp[3][4]);
    assign {c1[3], s1[3]} = fa(pp[7][1], pp[6][2], pp[5][3]);
    assign {c1[4], s1[4]} = ha(pp[4][4], pp[3][5]);
    assign {c1[5], s1[5]} = fa(pp[7][2], pp[6][3], pp[5][4]);

    // ********************
    // Height 6 to 4
    // ********************
    assign {c2[0], s2[0]}   = ha(pp[4][0], pp[3][1]);
    assign {c2[1], s2[1]}   = fa(pp[5][0], pp[4][1], pp[3][2]);
    assign {c2[2], s2[2]}   = ha(pp[2][3], pp[1][4]);
    assign {c2[3], s2[3]}   = fa(s1[0], pp[4][2], pp[3][3]);
    assign {c2[4], s2[4]}   = fa(pp[2][4], pp[1][5], pp[0][6]);
    assign {c2[5], s2[5]}   = fa(s1[1], s1[2], c1[0]);
    assign {c2[6], s2[6]}   = fa(pp[2][5], pp[1][6], pp[0][7]);
    assign {c2[7], s2[7]}   = fa(s1[3], s1[4], c1[1]);
    assign {c2[8], s2[8]}   = fa(c1[2], pp[2][6], pp[1][7]);
    assign {c2[9], s2[9]}   = fa(s1[5], c1[3], c1[4]);
    assign {c2[10], s2[10]} = fa(pp[4][5], pp[3][6], pp[2][7]);
    assign {c2[11], s2[11]} = fa(pp[7][3], c1[5], pp[6][4]);
    assign {c2[12], s2[12]} = fa(pp[5][5], pp[4][6], pp[3][7]);
    assign {c2[13], s2[13]} = fa(pp[7][4], pp[6][5], pp[5][6]);

    // ********************
    // Height 4 to 3
    // ********************
    assign {c3[0], s3[0]} = ha(pp[3][0], pp[2][1]);
    assign {c3[1], s3[1]} = fa(s2[0], pp[2][2], pp[1][3]);
    assign {c3[2], s3[2]} = fa(s2[1], s2[2], c2[0]);
    assign {c3[3], s3[3]} = fa(c2[1], c2[2], s2[3]);
    assign {c3[4], s3[4]} = fa(c2[3], c2[4], s2[5]);
    assign {c3[5], s3[5]} = fa(c2[5], c2[6], s2[7]);
    assign {c3[6], s3[6]} = fa(c2[7], c2[8], s2[9]);
    assign {c3[7], s3[7]} = fa(c2[9], c2[10], s2[11]);
    assign {c3[8], s3[8]} = fa(c2[11], c2[12], s2[13]);
    assign {c3[9], s3[9]} = fa(pp[7][5], pp[6][6], pp[5][7]);

    // ********************
    // Height 3 to 2
    // ********************
    assign {c4[0], s4[0]}   = ha(pp[2][0], pp[1][1]);
    assign {c4[1], s4[1]}   = fa(s3[0], pp[1][2], pp[0][3]);
    assign {c4[2], s4[2]}   = fa(c3[0], s3[1], pp[0][4]);
    assign {c4[3], s4[3]}   = fa(c3[1], s3[2], pp[0][5]);
    assign {c4[4], s4[4]}   = fa(c3[2], s3[3], s2[4]);
    assign {c4[5], s4[5]}   = fa(c3[3], s3[4], s2[6]);
    assign {c4[6], s4[6]}   = fa(c3[4], s3[5], s2[8]);
    assign {c4[7], s4[7]}   = fa(c3[5], s3[6], s2[10]);
    assign {c4[8], s4[8]}   = fa(c3[6], s3[7], s2[12]);
    assign {c4[9], s4[9]}   = fa(c3[7], s3[8], pp[4][7]);
    assign {c4[10], s4[10]} = fa(c3[8], s3[9], c2[13]);
    assign {c4[11], s4[11]} = fa(c3[9], pp[7][6], pp[6][7]);

    // ********************
    // Final ripple row
    // ********************
    // Two operands per column from 2 up to 14
    assign fin_x = {c4, s4[0]};
    assign fin_y = {pp[7][7], s4[11:1], pp[0][2]};

    assign y[0]            = pp[0][0];
    assign {cy[1], y[1]}   = ha(pp[1][0], pp[0][1]);

    for (genvar k = 2; k <= 14; k++) begin : g_ripple
        assign {cy[k], y[k]} = fa(fin_x[k], fin_y[k], cy[k-1]);
    end

    assign y[15] = cy[14];

endmodule

// ==== dadda_tile.sv ====
`timescale 1ns/100ps

module dadda_tile #(
    parameter int W = 64
) (
    input  logic [W-1:0]    a,
    input  logic [W-1:0]    b,
    output logic [2*W-1:0]  y
);

    if (W == mul_pkg::BASE_W) begin : g_leaf
        dadda_8x8 leaf_inst (
            .a (a),
            .b (b),
            .y (y)
        );
    end else begin : g_split
        localparam int H = W / 2;

        // Sub-products, named by the halves of a and b
        logic [W-1:0]      ll, lh, hl, hh;
        logic [W-1:0]      s1, c1;
        logic [W+H-3:0]    c2;

        dadda_tile #(.W(H)) ll_inst (.a(a[H-1:0]), .b(b[H-1:0]), .y(ll));
        dadda_tile #(.W(H)) lh_inst (.a(a[H-1:0]), .b(b[W-1:H]), .y(lh));
        dadda_tile #(.W(H)) hl_inst (.a(a[W-1:H]), .b(b[H-1:0]), .y(hl));
        dadda_tile #(.W(H)) hh_inst (.a(a[W-1:H]), .b(b[W-1:H]), .y(hh));

        // Low quarter is already final
        assign y[H-1:0] = ll[H-1:0];

        // Carry-save row over the three middle terms
        for (genvar i = 0; i < W; i++) begin : g_csa
            logic x;
            assign x     = (i < H) ? ll[i+H] : hh[i-H];
            assign s1[i] = x ^ lh[i] ^ hl[i];
            assign c1[i] = (x & lh[i]) | (x & hl[i]) | (lh[i] & hl[i]);
        end

        // Carry row merging sums and carries
        assign y[H]   = s1[0];
        assign y[H+1] = s1[1] ^ c1[0];
        assign c2[0]  = s1[1] & c1[0];

        for (genvar i = 2; i < W; i++) begin : g_carry
            assign y[i+H]  = s1[i] ^ c1[i-1] ^ c2[i-2];
            assign c2[i-1] = (s1[i] & c1[i-1]) | (s1[i] & c2[i-2]) | (c1[i-1] & c2[i-2]);
        end

        // Column W+H still has three inputs
        assign y[W+H] = hh[H] ^ c1[W-1] ^ c2[W-2];
        assign c2[W-1] = (hh[H] & c1[W-1]) | (hh[H] & c2[W-2]) | (c1[W-1] & c2[W-2]);

        // Top quarter by half-adder ripple
        for (genvar i = 0; i < H - 2; i++) begin : g_top
            assign y[i+W+H+1] = hh[i+H+1] ^ c2[i+W-1];
            assign c2[i+W]    = hh[i+H+1] & c2[i+W-1];
        end

        // Carry out of the top bit cannot occur
        assign y[2*W-1] = hh[W-1] ^ c2[W+H-3];
    end

endmodule

// ==== mul_decode.sv ====
`timescale 1ns/100ps

module mul_decode #(
    parameter int XLEN = mul_pkg::XLEN
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [mul_pkg::OPCODE_W-1:0]  in_opcode,
    input  logic [XLEN-1:0]               in_a,
    input  logic [XLEN-1:0]               in_b,
    op_if.src                             op
);

    mul_pkg::res_sel_t  sel_d;
    mul_pkg::res_sel_t  sel_q;
    logic               valid_q;
    logic [XLEN-1:0]    a_q;
    logic [XLEN-1:0]    b_q;

    // Opcode to result select, unknown opcodes give zero
    always_comb begin
        case (in_opcode)
            mul_pkg::OP_MUL:   sel_d = mul_pkg::SEL_LO;
            mul_pkg::OP_MULHU: sel_d = mul_pkg::SEL_HI;
            default:           sel_d = mul_pkg::SEL_ZERO;
        endcase
    end

    // Slot is free when empty or draining this cycle
    assign in_ready = !valid_q || op.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            a_q   <= in_a;
            b_q   <= in_b;
            sel_q <= sel_d;
        end
    end

    assign op.valid = valid_q;
    assign op.a     = a_q;
    assign op.b     = b_q;
    assign op.sel   = sel_q;

endmodule

// ==== mul_execute.sv ====
`timescale 1ns/100ps

module mul_execute #(
    parameter int XLEN = mul_pkg::XLEN
) (
    input  logic  clk,
    input  logic  rst,
    op_if.dst     op,
    prod_if.src   prod
);

    logic [2*XLEN-1:0]  prod_w;
    logic               valid_q;
    mul_pkg::product_u  prod_q;
    mul_pkg::res_sel_t  sel_q;

    // ********************
    // Multiplier
    // ********************
    // Works on the decode slot contents directly
    dadda_tile #(
        .W (XLEN)
    ) mult_inst (
        .a (op.a),
        .b (op.b),
        .y (prod_w)
    );

    // ********************
    // Slot register
    // ********************
    assign op.ready = !valid_q || prod.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (op.ready) begin
            valid_q <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid && op.ready) begin
            prod_q.whole <= prod_w;
            sel_q        <= op.sel;
        end
    end

    assign prod.valid = valid_q;
    assign prod.prod  = prod_q;
    assign prod.sel   = sel_q;

endmodule

// ==== mul_result.sv ====
`timescale 1ns/100ps

module mul_result #(
    parameter int XLEN = mul_pkg::XLEN
) (
    input  logic             clk,
    input  logic             rst,
    prod_if.dst              prod,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [XLEN-1:0]  out_result
);

    logic [XLEN-1:0]  pick;
    logic             valid_q;
    logic [XLEN-1:0]  result_q;

    // Same product word, read as one half or the other
    always_comb begin
        case (prod.sel)
            mul_pkg::SEL_LO: pick = prod.prod.half.lo;
            mul_pkg::SEL_HI: pick = prod.prod.half.hi;
            default:         pick = '0;
        endcase
    end

    // Holds while the consumer stalls
    assign prod.ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (prod.ready) begin
            valid_q <= prod.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod.valid && prod.ready) begin
            result_q <= pick;
        end
    end

    assign out_valid  = valid_q;
    assign out_result = result_q;

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit #(
    parameter int XLEN = mul_pkg::XLEN
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic [mul_pkg::OPCODE_W-1:0]  in_opcode,
    input  logic [XLEN-1:0]               in_a,
    input  logic [XLEN-1:0]               in_b,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [XLEN-1:0]               out_result
);

    // ********************
    // Stage links
    // ********************
    op_if #(.XLEN(XLEN)) op_link ();
    prod_if               prod_link ();

    // ********************
    // Pipeline stages
    // ********************
    mul_decode #(
        .XLEN (XLEN)
    ) decode_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_opcode (in_opcode),
        .in_a      (in_a),
        .in_b      (in_b),
        .op        (op_link)
    );

    mul_execute #(
        .XLEN (XLEN)
    ) execute_inst (
        .clk  (clk),
        .rst  (rst),
        .op   (op_link),
        .prod (prod_link)
    );

    mul_result #(
        .XLEN (XLEN)
    ) result_inst (
        .clk        (clk),
        .rst        (rst),
        .prod       (prod_link),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

endmodule

// ==== tb_mul_unit_sva.sv ====
`timescale 1ns/100ps

module tb_mul_unit_sva #(
    parameter int XLEN = mul_pkg::XLEN
) (
    input logic             clk,
    input logic             rst,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input logic [XLEN-1:0]  out_result
);

    // Output slot is empty once reset has been seen
    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during reset");

    // A stalled result keeps its value
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("output changed while out_ready was low");

    assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else $error("in_ready low right after reset");

endmodule

bind mul_unit tb_mul_unit_sva #(.XLEN(XLEN)) sva_inst (
    .clk        (clk),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

// ==== tb_mul_unit.sv ====
`timescale 1ns/100ps

module tb_mul_unit;

    localparam int XLEN       = mul_pkg::XLEN;
    localparam int CLK_PERIOD = 20;
    localparam int LATENCY    = 3;
    // Operations issued by all tests together
    localparam int N_OPS      = 39;
    localparam logic [4:0] MUL   = mul_pkg::OP_MUL;
    localparam logic [4:0] MULHU = mul_pkg::OP_MULHU;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    logic [4:0]       in_opcode;
    logic [XLEN-1:0]  in_a;
    logic [XLEN-1:0]  in_b;
    logic             out_valid;
    logic             out_ready;
    logic [XLEN-1:0]  out_result;
    logic [63:0]      lfsr;
    int               cycle = 0;
    int               pass_count = 0;
    int               fail_count = 0;
    logic [XLEN-1:0]  exp_q [$];
    int               acc_q [$];

    mul_unit #(.XLEN(XLEN)) mul_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(CLK_PERIOD * (N_OPS * 40 + 200));
        $display("Timeout: the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

    // ********************
    // Helpers
    // ********************
    // Fibonacci LFSR, taps 64 63 61 60
    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[62:0], lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59]};
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    // Full unsigned product, then the half named by the opcode
    function automatic logic [XLEN-1:0] expected(input logic [4:0] opc,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] p;
        p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        if (opc == MUL) return p[XLEN-1:0];
        if (opc == MULHU) return p[2*XLEN-1:XLEN];
        return '0;
    endfunction

    task automatic check(input string name, input logic [XLEN-1:0] exp_v,
                         input logic [XLEN-1:0] act);
        if (exp_v === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("ERR %s expected %h actual %h", name, exp_v, act);
        end
    endtask

    task automatic send(input logic [4:0] opc, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
        @(negedge clk);
        in_valid  = 1'b1;
        in_opcode = opc;
        in_a      = a;
        in_b      = b;
        #(CLK_PERIOD / 4);
        while (!in_ready) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        // The coming rising edge takes the operands
        acc_q.push_back(cycle + 1);
        exp_q.push_back(expected(opc, a, b));
        @(posedge clk);
    endtask

    task automatic idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Latency counts the accepting edge as the first cycle
    task automatic receive(input string name, output int latency);
        @(negedge clk);
        // Consumer takes results from here on
        out_ready = 1'b1;
        while (!(out_valid && out_ready)) @(negedge clk);
        latency = cycle - acc_q.pop_front() + 1;
        check(name, exp_q.pop_front(), out_result);
        @(posedge clk);
    endtask

    task automatic run_op(input string name, input logic [4:0] opc,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int lat;
        send(opc, a, b);
        idle();
        receive(name, lat);
        check({name, " latency"}, LATENCY, lat);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%s: %0d errors", name, fail_count - fails_before);
    endtask

    // ********************
    // Tests
    // ********************
    task automatic test_mul_corners();
        int fails;
        fails = fail_count;
        run_op("mul zero", MUL, '0, 64'h1234_5678_9abc_def0);
        run_op("mul one", MUL, 64'd1, 64'hfedc_ba98_7654_3210);
        run_op("mul ones", MUL, '1, '1);
        run_op("mul 2^63 x 2", MUL, 64'h8000_0000_0000_0000, 64'd2);
        run_op("mul 2^32 x 2^31", MUL, 64'h1_0000_0000, 64'h8000_0000);
        run_op("mul 2^40 x 3", MUL, 64'h100_0000_0000, 64'd3);
        report_test("mul_corners", fails);
    endtask

    task automatic test_mulhu_borders();
        int fails;
        fails = fail_count;
        run_op("mulhu zero", MULHU, '0, '1);
        run_op("mulhu one", MULHU, 64'd1, '1);
        run_op("mulhu ones", MULHU, '1, '1);
        run_op("mulhu 2^63 x 2", MULHU, 64'h8000_0000_0000_0000, 64'd2);
        run_op("mulhu 2^32 x 2^32", MULHU, 64'h1_0000_0000, 64'h1_0000_0000);
        run_op("mulhu 8 bit", MULHU, 64'h80ff_80ff_80ff_80ff, 64'hff01_ff01_ff01_ff01);
        run_op("mulhu 16 bit", MULHU, 64'hffff_0001_ffff_0001, 64'h8000_ffff_8000_ffff);
        run_op("mulhu 32 bit", MULHU, 64'hffff_ffff_0000_0001, 64'hffff_ffff_ffff_ffff);
        run_op("mulhu mixed", MULHU, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        report_test("mulhu_borders", fails);
    endtask

    task automatic test_other_opcodes();
        int fails;
        fails = fail_count;
        run_op("opcode 00000", 5'b00000, 64'h1234_5678, 64'h9abc_def0);
        run_op("opcode 01101", 5'b01101, '1, '1);
        run_op("opcode 11111", 5'b11111, 64'hdead_beef, 64'h3);
        report_test("other_opcodes", fails);
    endtask

    task automatic test_stream();
        int fails;
        int lat;
        logic [1:0] pick;
        logic [4:0] opc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        fails = fail_count;
        fork
            begin
                for (int i = 0; i < 16; i++) begin
                    pick = 2'(rand_bits(2));
                    opc  = pick[0] ? (pick[1] ? 5'b00011 : MULHU) : MUL;
                    a    = rand_bits(XLEN);
                    b    = rand_bits(XLEN);
                    send(opc, a, b);
                end
                idle();
            end
            begin
                for (int i = 0; i < 16; i++) begin
                    receive("stream", lat);
                    if (i == 0) check("stream first latency", LATENCY, lat);
                end
            end
        join
        report_test("stream", fails);
    endtask

    task automatic test_backpressure();
        int fails;
        int lat;
        fails = fail_count;
        @(negedge clk);
        out_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send(i[0] ? MULHU : MUL, rand_bits(XLEN), rand_bits(XLEN));
        end
        #(CLK_PERIOD / 4);
        check("backpressure in_ready", '0, in_ready);
        fork
            begin
                send(MULHU, rand_bits(XLEN), rand_bits(XLEN));
                send(MUL, rand_bits(XLEN), rand_bits(XLEN));
                idle();
            end
            begin
                // The first receive releases out_ready on the fourth falling edge
                repeat (3) @(negedge clk);
                repeat (5) receive("backpressure", lat);
            end
        join
        report_test("backpressure", fails);
    endtask

    initial begin
        lfsr      = 64'd15;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_opcode = '0;
        in_a      = '0;
        in_b      = '0;
        out_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_mul_corners();
        test_mulhu_borders();
        test_other_opcodes();
        test_stream();
        test_backpressure();
        repeat (4) @(negedge clk);
        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== mul_unit.f ====
mul_pkg.sv
mul_if.sv
dadda_8x8.sv
dadda_tile.sv
mul_decode.sv
mul_execute.sv
mul_result.sv
mul_unit.sv
tb_mul_unit_sva.sv
tb_mul_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mul_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mul_unit \
    -f mul_unit.f -o sim_mul_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_mul_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
